// File: source/dsp_route_pkg.sv
// shared router types and numbering; 16 sources max (4-bit selects), source 14 is reserved
package dsp_route_pkg;

   // widths
   localparam int sample_w = 14;          // adc/dac sample
   localparam int sel_w    = 4;           // source number
   localparam int acc_w    = 18;          // adder tree, 16 inputs worst case
   localparam int n_slots  = 8;           // processing slots
   localparam int n_sinks  = 12;          // slots + 2 scopes + 2 pwm
   localparam int n_direct = 10;          // slots + 2 generators
   localparam int n_src    = 2**sel_w;

   // dac clamp limits
   localparam int sample_max = 2**(sample_w-1) - 1;
   localparam int sample_min = -(2**(sample_w-1));

   typedef logic signed [sample_w-1:0] sample_t;
   typedef logic [sel_w-1:0]           sel_t;
   typedef logic [1:0]                 outsel_t;   // bit 0 dac a, bit 1 dac b

   // source numbers, slots are 0..7
   localparam sel_t src_gen_a  = 4'd8;
   localparam sel_t src_gen_b  = 4'd9;
   localparam sel_t src_adc_a  = 4'd10;
   localparam sel_t src_adc_b  = 4'd11;
   localparam sel_t src_dac_a  = 4'd12;    // dac outputs fed back
   localparam sel_t src_dac_b  = 4'd13;
   localparam sel_t src_unused = 4'd14;    // reads zero
   localparam sel_t src_none   = 4'd15;    // reads zero

   // sink numbers, slots are 0..7
   localparam int sink_scope_a = 8;
   localparam int sink_scope_b = 9;
   localparam int sink_pwm_a   = 10;
   localparam int sink_pwm_b   = 11;

   // register offsets, addr[15:0]; the entry index sits in addr[19:16]
   localparam logic [15:0] off_insel  = 16'h0000;
   localparam logic [15:0] off_outsel = 16'h0004;
   localparam logic [15:0] off_status = 16'h0008;
   localparam logic [15:0] off_sync   = 16'h000C;
   localparam logic [15:0] off_signal = 16'h0010;

   // output enable codes
   localparam outsel_t en_off  = 2'b00;
   localparam outsel_t en_a    = 2'b01;
   localparam outsel_t en_b    = 2'b10;
   localparam outsel_t en_both = 2'b11;

   // bus request, enable pulse style
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        wen;
      logic        ren;
   } sys_req_t;

   // bus response, valid one cycle after the request
   typedef struct packed {
      logic [31:0] rdata;
      logic        ack;
      logic        err;     // only with ack
   } sys_rsp_t;

   // routing config
   typedef struct packed {
      sel_t    [n_sinks-1:0]  insel;    // source per sink
      outsel_t [n_direct-1:0] outsel;   // dac enables per direct signal
   } route_cfg_t;

   typedef sample_t [n_src-1:0]    src_bundle_t;
   typedef sample_t [n_direct-1:0] direct_bundle_t;
   typedef sample_t [n_sinks-1:0]  sink_bundle_t;
   typedef sample_t [n_slots-1:0]  slot_bundle_t;

endpackage

// File: source/signal_crossbar.sv
// purely combinational source select; selects 14 and 15 force the sink to zero
`timescale 1ns/1ns

module signal_crossbar (
   input  dsp_route_pkg::src_bundle_t  src_i,
   input  dsp_route_pkg::route_cfg_t   cfg_i,
   output dsp_route_pkg::sink_bundle_t sink_o
);
   import dsp_route_pkg::*;

   // one mux per sink
   always_comb begin
      for (int k = 0; k < n_sinks; k++) begin
         if (cfg_i.insel[k] == src_none || cfg_i.insel[k] == src_unused) begin
            sink_o[k] = '0;                     // nothing routed
         end else begin
            sink_o[k] = src_i[cfg_i.insel[k]];
         end
      end
   end

endmodule

// File: source/dac_sum_tree.sv
// 5-stage adder tree per dac, sum clamped to 14 bits; no stall, new inputs every cycle
`timescale 1ns/1ns

module dac_sum_tree (
   input  logic                          clk_i,
   input  logic                          rstn_i,
   input  dsp_route_pkg::direct_bundle_t direct_i,
   input  dsp_route_pkg::route_cfg_t     cfg_i,
   output dsp_route_pkg::sample_t        dac_a_o,
   output dsp_route_pkg::sample_t        dac_b_o,
   output logic [1:0]                    sat_o      // bit 0 dac a, bit 1 dac b
);
   import dsp_route_pkg::*;

   localparam int n_pairs = 8;           // 16 leaf slots, 10 used

   sample_t dac_sat [2];                 // clamped result per dac

   for (genvar d = 0; d < 2; d++) begin : g_dac
      localparam outsel_t dac_bit = (d == 0) ? en_a : en_b;

      logic signed [acc_w-1:0] term   [2*n_pairs];   // gated, sign extended leaves
      logic signed [acc_w-1:0] pair_q [n_pairs];     // stage 1
      logic signed [acc_w-1:0] lvl1_q [4];           // stage 2
      logic signed [acc_w-1:0] lvl2_q [2];           // stage 3
      logic signed [acc_w-1:0] lvl3_q;               // stage 4
      logic signed [acc_w-1:0] sum_q;                // stage 5, final register
      logic                    ovf;

      // leaves beyond n_direct stay zero
      always_comb begin
         term = '{default: '0};
         for (int i = 0; i < n_direct; i++) begin
            if (|(cfg_i.outsel[i] & dac_bit)) begin
               term[i] = {{(acc_w-sample_w){direct_i[i][sample_w-1]}}, direct_i[i]};
            end
         end
      end

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            pair_q <= '{default: '0};
            lvl1_q <= '{default: '0};
            lvl2_q <= '{default: '0};
            lvl3_q <= '0;
            sum_q  <= '0;              // dac comes up at 0
         end else begin
            for (int p = 0; p < n_pairs; p++) begin
               pair_q[p] <= term[2*p] + term[2*p+1];
            end
            for (int q = 0; q < 4; q++) begin
               lvl1_q[q] <= pair_q[2*q] + pair_q[2*q+1];
            end
            lvl2_q[0] <= lvl1_q[0] + lvl1_q[1];
            lvl2_q[1] <= lvl1_q[2] + lvl1_q[3];
            lvl3_q    <= lvl2_q[0] + lvl2_q[1];
            sum_q     <= lvl3_q;      // extra stage for slack
         end
      end

      // clamp after the final register
      always_comb begin
         ovf = 1'b0;
         if (sum_q > sample_max) begin
            dac_sat[d] = sample_t'(sample_max);
            ovf        = 1'b1;
         end else if (sum_q < sample_min) begin
            dac_sat[d] = sample_t'(sample_min);
            ovf        = 1'b1;
         end else begin
            dac_sat[d] = sum_q[sample_w-1:0];   // in range, plain truncate
         end
      end

      assign sat_o[d] = ovf;

      // overflow always leaves the dac pinned at the limit of the sum's sign
      assert property (@(posedge clk_i) disable iff (!rstn_i)
         sat_o[d] |-> (sum_q[acc_w-1] ? dac_sat[d] == sample_t'(sample_min)
                                      : dac_sat[d] == sample_t'(sample_max)))
         else $error("dac %0d overflow without clamp", d);
   end

   assign dac_a_o = dac_sat[0];
   assign dac_b_o = dac_sat[1];

endmodule

// File: source/route_regs.sv
// routing registers; no wait states, unknown offsets ack with err, bad index reads zero
`timescale 1ns/1ns

module route_regs (
   input  logic                        clk_i,
   input  logic                        rstn_i,
   input  dsp_route_pkg::sys_req_t     sys_req_i,
   input  dsp_route_pkg::src_bundle_t  src_i,      // signal readback
   input  logic [1:0]                  sat_i,      // dac b, dac a
   output dsp_route_pkg::route_cfg_t   cfg_o,
   output logic [7:0]                  sync_o,
   output dsp_route_pkg::sys_rsp_t     sys_rsp_o
);
   import dsp_route_pkg::*;

   logic [15:0]        offset;
   logic [3:0]         idx;          // entry index
   logic               req;          // any bus access this cycle

   route_cfg_t         cfg_q;
   logic [n_slots-1:0] sync_q;

   logic [31:0]        rdata;        // read mux
   logic               err;
   logic [31:0]        rdata_q;
   logic               ack_q;
   logic               err_q;

   assign offset = sys_req_i.addr[15:0];
   assign idx    = sys_req_i.addr[19:16];
   assign req    = sys_req_i.wen | sys_req_i.ren;

   // config writes
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < n_slots; k++) begin
            cfg_q.insel[k] <= src_adc_a;           // all slots listen to adc a
         end
         cfg_q.insel[sink_scope_a] <= src_adc_a;
         cfg_q.insel[sink_scope_b] <= src_adc_b;
         cfg_q.insel[sink_pwm_a]   <= src_none;     // pwm off
         cfg_q.insel[sink_pwm_b]   <= src_none;
         cfg_q.outsel              <= {n_direct{en_off}};
         sync_q                    <= '1;           // all slots running
      end else if (sys_req_i.wen) begin
         case (offset)
            off_insel: begin
               if (idx < n_sinks) begin
                  cfg_q.insel[idx] <= sys_req_i.wdata[sel_w-1:0];
               end
            end
            off_outsel: begin
               if (idx < n_direct) begin
                  cfg_q.outsel[idx] <= sys_req_i.wdata[1:0];
               end
            end
            off_sync: sync_q <= sys_req_i.wdata[n_slots-1:0];
            default: ;                               // status and signal are read only
         endcase
      end
   end

   // read mux, zero extended
   always_comb begin
      rdata = '0;
      err   = 1'b0;
      case (offset)
         off_insel: begin
            if (idx < n_sinks) begin
               rdata[sel_w-1:0] = cfg_q.insel[idx];
            end
         end
         off_outsel: begin
            if (idx < n_direct) begin
               rdata[1:0] = cfg_q.outsel[idx];
            end
         end
         off_status: rdata[1:0]          = sat_i;
         off_sync:   rdata[n_slots-1:0]  = sync_q;
         off_signal: rdata[sample_w-1:0] = src_i[idx];   // raw bits, no sign ext
         default:    err = 1'b1;                         // not ours
      endcase
   end

   // handshake, ack exactly one cycle after the request
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req;
         err_q <= req & err;
      end
   end

   // read data only matters with ack
   always_ff @(posedge clk_i) begin
      if (req) begin
         rdata_q <= rdata;
      end
   end

   assign cfg_o     = cfg_q;
   assign sync_o    = sync_q;
   assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

   // err never shows up on its own
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_rsp_o.err |-> sys_rsp_o.ack)
      else $error("bus err without ack");

   // no spontaneous ack
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_rsp_o.ack |-> $past(req))
      else $error("bus ack without request");

endmodule

// File: source/dsp_router.sv
// router top; slots are external, dac outputs arrive 5 cycles after the direct inputs
`timescale 1ns/1ns

module dsp_router (
   input  logic                          clk_i,
   input  logic                          rstn_i,
   // converters and generators
   input  dsp_route_pkg::sample_t        adc_a_i,
   input  dsp_route_pkg::sample_t        adc_b_i,
   input  dsp_route_pkg::sample_t        gen_a_i,
   input  dsp_route_pkg::sample_t        gen_b_i,
   // external processing slots
   input  dsp_route_pkg::slot_bundle_t   slot_out_i,
   output dsp_route_pkg::slot_bundle_t   slot_in_o,
   output logic [7:0]                    sync_o,
   // outputs
   output dsp_route_pkg::sample_t        dac_a_o,
   output dsp_route_pkg::sample_t        dac_b_o,
   output dsp_route_pkg::sample_t        scope_a_o,
   output dsp_route_pkg::sample_t        scope_b_o,
   output dsp_route_pkg::sample_t        pwm_a_o,
   output dsp_route_pkg::sample_t        pwm_b_o,
   // system bus
   input  dsp_route_pkg::sys_req_t       sys_req_i,
   output dsp_route_pkg::sys_rsp_t       sys_rsp_o
);
   import dsp_route_pkg::*;

   src_bundle_t    src;      // everything a sink can pick
   direct_bundle_t direct;   // everything that can add into a dac
   sink_bundle_t   sink;
   route_cfg_t     cfg;
   logic [1:0]     sat;      // dac b, dac a

   // slots first, then the generators
   assign direct = {gen_b_i, gen_a_i, slot_out_i};

   always_comb begin
      src                 = '0;          // 14 and src_none stay zero
      src[n_slots-1:0]    = slot_out_i;
      src[src_gen_a]      = gen_a_i;
      src[src_gen_b]      = gen_b_i;
      src[src_adc_a]      = adc_a_i;
      src[src_adc_b]      = adc_b_i;
      src[src_dac_a]      = dac_a_o;     // registered, no comb loop
      src[src_dac_b]      = dac_b_o;
   end

   signal_crossbar signal_crossbar_i (
      .src_i  (src),
      .cfg_i  (cfg),
      .sink_o (sink)
   );

   dac_sum_tree dac_sum_tree_i (
      .clk_i    (clk_i),
      .rstn_i   (rstn_i),
      .direct_i (direct),
      .cfg_i    (cfg),
      .dac_a_o  (dac_a_o),
      .dac_b_o  (dac_b_o),
      .sat_o    (sat)
   );

   route_regs route_regs_i (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .sys_req_i (sys_req_i),
      .src_i     (src),
      .sat_i     (sat),
      .cfg_o     (cfg),
      .sync_o    (sync_o),
      .sys_rsp_o (sys_rsp_o)
   );

   // split the sinks back out
   assign slot_in_o = sink[n_slots-1:0];
   assign scope_a_o = sink[sink_scope_a];
   assign scope_b_o = sink[sink_scope_b];
   assign pwm_a_o   = sink[sink_pwm_a];
   assign pwm_b_o   = sink[sink_pwm_b];

endmodule

// File: verif/dsp_router_tb.sv
// random stimulus from one seed, inputs move on the falling edge; all checks are concurrent asserts
`timescale 1ns/1ns

module dsp_router_tb;
   import dsp_route_pkg::*;

   localparam int n_phases = 5;
   localparam int n_iter   = 40;          // iterations per phase

   logic         clk_i = 1'b0;
   logic         rstn_i;
   sample_t      adc_a_i, adc_b_i, gen_a_i, gen_b_i;
   slot_bundle_t slot_out_i;
   slot_bundle_t slot_in_o;
   logic [7:0]   sync_o;
   sample_t      dac_a_o, dac_b_o, scope_a_o, scope_b_o, pwm_a_o, pwm_b_o;
   sys_req_t     sys_req_i;
   sys_rsp_t     sys_rsp_o;

   // reference model
   sel_t         model_insel  [n_sinks];
   outsel_t      model_outsel [n_direct];
   logic [7:0]   model_sync;
   int           pipe_a [5];              // expected sums, one per register stage
   int           pipe_b [5];
   sample_t      exp_src  [n_src];        // model view of every source
   sample_t      exp_sink [n_sinks];
   sample_t      exp_dac_a, exp_dac_b;
   logic [1:0]   exp_sat;
   logic         exp_err;                 // pending bus access
   logic         rd_chk;
   logic [31:0]  exp_rdata;

   dsp_router dsp_router_i (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .gen_a_i    (gen_a_i),
      .gen_b_i    (gen_b_i),
      .slot_out_i (slot_out_i),
      .slot_in_o  (slot_in_o),
      .sync_o     (sync_o),
      .dac_a_o    (dac_a_o),
      .dac_b_o    (dac_b_o),
      .scope_a_o  (scope_a_o),
      .scope_b_o  (scope_b_o),
      .pwm_a_o    (pwm_a_o),
      .pwm_b_o    (pwm_b_o),
      .sys_req_i  (sys_req_i),
      .sys_rsp_o  (sys_rsp_o)
   );

   always #2 clk_i = ~clk_i;              // 4 ns period

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic mismatch(input string name, input int expected, input int actual);
      fail_run($sformatf("[ERROR] %0t ns %s expected %0d actual %0d",
                         $time, name, expected, actual));
   endtask

   // dac range is -8192..8191
   function automatic sample_t clamp_sum(input int sum);
      if (sum > 8191) return sample_t'(8191);
      if (sum < -8192) return sample_t'(-8192);
      return sample_t'(sum);
   endfunction

   function automatic logic sat_flag(input int sum);
      return (sum > 8191) || (sum < -8192);
   endfunction

   // signed sum of the direct signals enabled for one dac, 0 = a, 1 = b
   function automatic int enabled_sum(input int dac);
      int      acc;
      sample_t v;
      acc = 0;
      for (int i = 0; i < n_direct; i++) begin
         v = (i < n_slots) ? slot_out_i[i] : ((i == n_slots) ? gen_a_i : gen_b_i);
         if (model_outsel[i][dac]) acc += int'(v);
      end
      return acc;
   endfunction

   function automatic logic known_offset(input logic [15:0] off);
      return off inside {off_insel, off_outsel, off_status, off_sync, off_signal};
   endfunction

   function automatic logic [31:0] expect_read(input logic [15:0] off, input logic [3:0] idx);
      logic [31:0] v;
      v = '0;
      case (off)
         off_insel:  if (idx < 4'd12) v[3:0] = model_insel[idx];   // 12..15 read zero
         off_outsel: if (idx < 4'd10) v[1:0] = model_outsel[idx];
         off_status: v[1:0]  = exp_sat;
         off_sync:   v[7:0]  = model_sync;
         off_signal: v[13:0] = exp_src[idx];                      // raw bits
         default:    v = '0;
      endcase
      return v;
   endfunction

   always_comb begin
      exp_dac_a = clamp_sum(pipe_a[4]);
      exp_dac_b = clamp_sum(pipe_b[4]);
      exp_sat   = {sat_flag(pipe_b[4]), sat_flag(pipe_a[4])};
      for (int s = 0; s < n_src; s++) begin
         exp_src[s] = '0;                                     // 14 and 15 stay zero
      end
      for (int s = 0; s < n_slots; s++) begin
         exp_src[s] = slot_out_i[s];
      end
      exp_src[8]  = gen_a_i;
      exp_src[9]  = gen_b_i;
      exp_src[10] = adc_a_i;
      exp_src[11] = adc_b_i;
      exp_src[12] = exp_dac_a;                                // feedback
      exp_src[13] = exp_dac_b;
      for (int k = 0; k < n_sinks; k++) begin
         exp_sink[k] = exp_src[model_insel[k]];
      end
   end

   // five stages, pair sums through the final register
   always @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int s = 0; s < 5; s++) begin
            pipe_a[s] <= 0;
            pipe_b[s] <= 0;
         end
      end else begin
         pipe_a[0] <= enabled_sum(0);
         pipe_b[0] <= enabled_sum(1);
         for (int s = 1; s < 5; s++) begin
            pipe_a[s] <= pipe_a[s-1];
            pipe_b[s] <= pipe_b[s-1];
         end
      end
   end

   for (genvar k = 0; k < n_slots; k++) begin : g_slot_chk
      assert property (@(posedge clk_i) disable iff (!rstn_i) slot_in_o[k] == exp_sink[k])
         else mismatch($sformatf("slot_in_o[%0d]", k), int'($sampled(exp_sink[k])),
                       int'($sampled(slot_in_o[k])));
   end
   assert property (@(posedge clk_i) disable iff (!rstn_i) scope_a_o == exp_sink[sink_scope_a])
      else mismatch("scope_a_o", int'($sampled(exp_sink[sink_scope_a])), int'($sampled(scope_a_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) scope_b_o == exp_sink[sink_scope_b])
      else mismatch("scope_b_o", int'($sampled(exp_sink[sink_scope_b])), int'($sampled(scope_b_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) pwm_a_o == exp_sink[sink_pwm_a])
      else mismatch("pwm_a_o", int'($sampled(exp_sink[sink_pwm_a])), int'($sampled(pwm_a_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) pwm_b_o == exp_sink[sink_pwm_b])
      else mismatch("pwm_b_o", int'($sampled(exp_sink[sink_pwm_b])), int'($sampled(pwm_b_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) dac_a_o == exp_dac_a)
      else mismatch("dac_a_o", int'($sampled(exp_dac_a)), int'($sampled(dac_a_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) dac_b_o == exp_dac_b)
      else mismatch("dac_b_o", int'($sampled(exp_dac_b)), int'($sampled(dac_b_o)));
   assert property (@(posedge clk_i) disable iff (!rstn_i) sync_o == model_sync)
      else mismatch("sync_o", int'($sampled(model_sync)), int'($sampled(sync_o)));

   // bus handshake, ack exactly one cycle after each request
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      (sys_req_i.wen || sys_req_i.ren) |=> sys_rsp_o.ack)
      else fail_run("bus request was not acknowledged on the next cycle");
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_rsp_o.ack |-> $past(sys_req_i.wen || sys_req_i.ren))
      else fail_run("bus acknowledge came without a request in the previous cycle");
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_rsp_o.err == (sys_rsp_o.ack && exp_err))
      else mismatch("sys_rsp_o.err", int'($sampled(sys_rsp_o.ack && exp_err)),
                    int'($sampled(sys_rsp_o.err)));
   assert property (@(posedge clk_i) disable iff (!rstn_i)
      (sys_rsp_o.ack && rd_chk) |-> sys_rsp_o.rdata == exp_rdata)
      else mismatch("sys_rsp_o.rdata", int'($sampled(exp_rdata)), int'($sampled(sys_rsp_o.rdata)));

   // one-cycle request, then wait for the ack
   task automatic bus_cycle(input logic wr, input logic [15:0] off, input logic [3:0] idx,
                            input logic [31:0] wdata);
      int waited;
      @(negedge clk_i);
      sys_req_i = '{addr: {12'h000, idx, off}, wdata: wdata, wen: wr, ren: !wr};
      exp_err   = !known_offset(off);
      rd_chk    = !wr && known_offset(off);    // rdata of an error is not defined
      exp_rdata = expect_read(off, idx);
      @(negedge clk_i);
      sys_req_i.wen = 1'b0;
      sys_req_i.ren = 1'b0;
      waited = 0;
      while (!sys_rsp_o.ack && waited < 8) begin
         @(negedge clk_i);
         waited++;
      end
      if (!sys_rsp_o.ack) fail_run("no bus acknowledge within 8 cycles");
   endtask

   // the dut took the write on the last rising edge, model follows now
   task automatic reg_write(input logic [15:0] off, input logic [3:0] idx, input logic [31:0] data);
      bus_cycle(1'b1, off, idx, data);
      if (off == off_insel && idx < 4'd12) model_insel[idx] = sel_t'(data[3:0]);
      if (off == off_outsel && idx < 4'd10) model_outsel[idx] = outsel_t'(data[1:0]);
      if (off == off_sync) model_sync = data[7:0];
   endtask

   task automatic randomize_inputs(input int shift);
      adc_a_i = sample_t'($urandom);
      adc_b_i = sample_t'($urandom);
      gen_a_i = sample_t'($urandom) >>> shift;             // shift keeps some sums in range
      gen_b_i = sample_t'($urandom) >>> shift;
      for (int s = 0; s < n_slots; s++) begin
         slot_out_i[s] = sample_t'($urandom) >>> shift;
      end
   endtask

   task automatic drive_all(input sample_t v);
      gen_a_i = v;
      gen_b_i = v;
      for (int s = 0; s < n_slots; s++) begin
         slot_out_i[s] = v;
      end
   endtask

   initial begin
      #(n_phases * n_iter * 20 * 4);
      fail_run("timeout: the test sequence did not finish in time");
   end

   initial begin
      void'($urandom(27391));
      rstn_i     = 1'b0;
      adc_a_i    = '0;
      adc_b_i    = '0;
      gen_a_i    = '0;
      gen_b_i    = '0;
      slot_out_i = '0;
      sys_req_i  = '0;
      exp_err    = 1'b0;
      rd_chk     = 1'b0;
      exp_rdata  = '0;
      for (int k = 0; k < n_sinks; k++) begin
         model_insel[k] = (k < 8) ? 4'd10 : ((k == 9) ? 4'd11 : ((k == 8) ? 4'd10 : 4'd15));
      end
      for (int d = 0; d < n_direct; d++) begin
         model_outsel[d] = 2'b00;
      end
      model_sync = 8'hff;
      repeat (5) @(negedge clk_i);
      rstn_i = 1'b1;

      // reset defaults
      randomize_inputs(0);
      repeat (4) @(negedge clk_i);
      bus_cycle(1'b0, off_insel, 4'd0, '0);
      bus_cycle(1'b0, off_sync, 4'd0, '0);

      // routing, a few enables first so the dac feedback is not idle
      reg_write(off_outsel, 4'd0, 32'(en_a));
      reg_write(off_outsel, 4'd8, 32'(en_b));
      for (int n = 0; n < n_iter; n++) begin
         reg_write(off_insel, 4'($urandom_range(n_sinks - 1)), 32'($urandom_range(15)));
         randomize_inputs(2);
         @(negedge clk_i);
         randomize_inputs(2);
      end

      // summing, held inputs then back to back
      for (int n = 0; n < n_iter; n++) begin
         reg_write(off_outsel, 4'($urandom_range(n_direct - 1)), 32'($urandom_range(3)));
         randomize_inputs(n % 4);
         repeat (6) @(negedge clk_i);
      end
      for (int n = 0; n < 4 * n_iter; n++) begin
         @(negedge clk_i);
         randomize_inputs(n % 5);
      end

      // saturation at both limits, status read back
      for (int d = 0; d < n_direct; d++) begin
         reg_write(off_outsel, 4'(d), 32'(en_a));
      end
      drive_all(sample_t'(8000));
      repeat (6) @(negedge clk_i);
      bus_cycle(1'b0, off_status, 4'd0, '0);
      for (int d = 0; d < n_direct; d++) begin
         reg_write(off_outsel, 4'(d), 32'(en_b));
      end
      drive_all(sample_t'(-8000));
      repeat (6) @(negedge clk_i);
      bus_cycle(1'b0, off_status, 4'd0, '0);

      // bus readback, unused indices, sync and errors
      for (int i = 0; i < 16; i++) begin
         bus_cycle(1'b0, off_insel, 4'(i), '0);
         bus_cycle(1'b0, off_outsel, 4'(i), '0);
         bus_cycle(1'b0, off_signal, 4'(i), '0);
      end
      for (int n = 0; n < n_iter / 4; n++) begin
         reg_write(off_sync, 4'd0, $urandom);
         bus_cycle(1'b0, off_sync, 4'd0, '0);
      end
      reg_write(off_insel, 4'd13, 32'd5);                    // no such sink, ignored
      bus_cycle(1'b0, off_insel, 4'd13, '0);
      reg_write(off_status, 4'd0, 32'hffff_ffff);            // read only
      reg_write(16'h0014, 4'd0, 32'd1);
      bus_cycle(1'b0, 16'h0100, 4'd2, '0);
      repeat (6) @(negedge clk_i);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: dsp_router.f
source/dsp_route_pkg.sv
source/signal_crossbar.sv
source/dac_sum_tree.sv
source/route_regs.sv
source/dsp_router.sv
verif/dsp_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module dsp_router_tb \
   -f dsp_router.f \
   -o sim_dsp_router

status=0
./obj_dir/sim_dsp_router > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
   echo "run_sim: FAIL"
   exit 1
fi
echo "run_sim: PASS"
exit 0
